// File: sim.f
audio_pkg.sv
sample_intake.sv
dsm_modulator.sv
pdm_output_stage.sv
audio_dac_top.sv
audio_dac_chk.sv
audio_dac_monitor.sv
audio_dac_tb.sv

// File: Bender.yml
package:
  name: audio_dac

sources:
  - audio_pkg.sv
  - sample_intake.sv
  - dsm_modulator.sv
  - pdm_output_stage.sv
  - audio_dac_top.sv
  - target: test
    files:
      - audio_dac_chk.sv
      - audio_dac_monitor.sv
      - audio_dac_tb.sv

// File: audio_dac_tb.sv
`timescale 1ns/1ps

module audio_dac_tb;

  localparam int hold_limit = 4096;
  localparam int window_log2 = 12;
  localparam int clk_period = 20;
  localparam int reset_cycles = 10;
  localparam int num_rows = 10;

  typedef struct {
    audio_pkg::dsm_order_e order;
    logic signed [audio_pkg::sample_w-1:0] sample;
    int windows;
    int density;
    bit stall;
  } row_t;

  // order, sample, checked windows, density in 1/1024, source stalls
  row_t rows [0:num_rows-1] = '{
    '{audio_pkg::order_first,  16'sh8000, 2, 64,  1'b0},
    '{audio_pkg::order_first,  16'shC000, 2, 192, 1'b0},
    '{audio_pkg::order_first,  16'sh0000, 2, 320, 1'b0},
    '{audio_pkg::order_first,  16'sh2EE0, 2, 414, 1'b0},
    '{audio_pkg::order_first,  16'sh7FFF, 2, 576, 1'b0},
    '{audio_pkg::order_second, 16'sh8000, 2, 64,  1'b0},
    '{audio_pkg::order_second, 16'sh0000, 2, 256, 1'b0},
    '{audio_pkg::order_second, 16'sh4000, 2, 352, 1'b0},
    '{audio_pkg::order_second, 16'sh7FFF, 2, 448, 1'b0},
    // random samples, windows only size the time budget
    '{audio_pkg::order_first,  16'sh0000, 5, 0,   1'b1}
  };

  logic clk = 1'b0;
  logic rst;
  logic signed [audio_pkg::sample_w-1:0] sample;
  logic sample_strobe;
  audio_pkg::dsm_order_e order;
  logic pdm_out;
  logic underrun;
  logic [window_log2:0] level;
  logic level_valid;

  logic strobe_en;
  logic [5:0] strobe_cnt;
  logic check_en;
  int exp_density;
  int value_errors;
  int protocol_errors;

  always #(clk_period / 2) clk = ~clk;

  audio_dac_top #(
    .hold_limit (hold_limit),
    .window_log2(window_log2)
  ) u_audio_dac_top (
    .clk          (clk),
    .rst          (rst),
    .sample       (sample),
    .sample_strobe(sample_strobe),
    .order        (order),
    .pdm_out      (pdm_out),
    .underrun     (underrun),
    .level        (level),
    .level_valid  (level_valid)
  );

  audio_dac_monitor #(
    .hold_limit (hold_limit),
    .window_log2(window_log2)
  ) u_monitor (
    .clk            (clk),
    .rst            (rst),
    .order          (order),
    .check_en       (check_en),
    .exp_density    (exp_density),
    .sample_strobe  (sample_strobe),
    .underrun       (underrun),
    .level          (level),
    .level_valid    (level_valid),
    .value_errors   (value_errors),
    .protocol_errors(protocol_errors)
  );

  // one strobe every 64 cycles while enabled
  always @(posedge clk) begin
    if (strobe_en) begin
      strobe_cnt <= strobe_cnt + 1'b1;
      sample_strobe <= (strobe_cnt == 6'd0);
    end else begin
      strobe_cnt <= '0;
      sample_strobe <= 1'b0;
    end
  end

  // ideal pulse density in 1/1024 units, rounded
  function automatic int expected_density(input audio_pkg::dsm_order_e ord,
                                          input logic signed [15:0] s);
    int num;
    int d;
    if (ord == audio_pkg::order_first) begin
      num = int'(s) + 32'h8000 + 32'h2000;
      d = (num * 1024 + 32'h10000) / 32'h20000;
    end else begin
      num = 3 * int'(s) + 32'h20000;
      d = (num * 1024 + 32'h40000) / 32'h80000;
      if (d > 512) begin
        d = 512;
      end
    end
    return d;
  endfunction

  function automatic longint run_budget_ns();
    longint cycles;
    cycles = 0;
    foreach (rows[i]) begin
      cycles += reset_cycles + (rows[i].windows + 1) * (1 << window_log2);
    end
    return cycles * clk_period * 2;
  endfunction

  task automatic apply_reset(input audio_pkg::dsm_order_e ord);
    @(posedge clk);
    rst <= 1'b1;
    order <= ord;
    strobe_en <= 1'b0;
    check_en <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic wait_level_valid();
    @(posedge clk);
    while (!level_valid) @(posedge clk);
  endtask

  task automatic run_steady_row(input row_t r);
    sample <= r.sample;
    exp_density <= r.density;
    strobe_en <= 1'b1;
    // first window holds the reset transient
    wait_level_valid();
    check_en <= 1'b1;
    repeat (r.windows) wait_level_valid();
    check_en <= 1'b0;
    strobe_en <= 1'b0;
  endtask

  task automatic run_stall_row(input audio_pkg::dsm_order_e ord);
    logic signed [15:0] fill;
    fill = 16'($urandom());
    sample <= fill;
    exp_density <= expected_density(ord, fill);
    strobe_en <= 1'b1;
    wait_level_valid();
    check_en <= 1'b1;
    wait_level_valid();
    check_en <= 1'b0;
    strobe_en <= 1'b0;
    // source stops, watchdog bounds the wait
    @(posedge clk);
    while (!underrun) @(posedge clk);
    // this window mixes live and silent samples
    wait_level_valid();
    exp_density <= expected_density(ord, 16'sh0000);
    check_en <= 1'b1;
    wait_level_valid();
    // single strobe right at the window start
    fill = 16'($urandom());
    sample <= fill;
    exp_density <= expected_density(ord, fill);
    strobe_en <= 1'b1;
    @(posedge clk);
    strobe_en <= 1'b0;
    wait_level_valid();
    check_en <= 1'b0;
  endtask

  initial begin
    int assert_errors;
    rst = 1'b1;
    sample = '0;
    sample_strobe = 1'b0;
    order = audio_pkg::order_first;
    strobe_en = 1'b0;
    strobe_cnt = '0;
    check_en = 1'b0;
    exp_density = 0;
    void'($urandom(32'hea9f));

    for (int i = 0; i < num_rows; i++) begin
      apply_reset(rows[i].order);
      if (rows[i].stall) begin
        run_stall_row(rows[i].order);
      end else begin
        run_steady_row(rows[i]);
      end
    end

    repeat (2) @(posedge clk);
    assert_errors = u_audio_dac_top.u_chk.assert_errors;
    $display("errors: value %0d, protocol %0d, assertion %0d",
             value_errors, protocol_errors, assert_errors);
    if (value_errors + protocol_errors + assert_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    longint budget;
    budget = run_budget_ns();
    #(budget);
    $display("timeout: the run did not finish within %0d ns", budget);
    $display("test failed");
    $finish;
  end

endmodule

// File: audio_dac_monitor.sv
`timescale 1ns/1ps

module audio_dac_monitor #(
  parameter int hold_limit = 4096,
  parameter int window_log2 = 12
) (
  input  logic                  clk,
  input  logic                  rst,
  input  audio_pkg::dsm_order_e order,
  input  logic                  check_en,
  input  int                    exp_density,
  input  logic                  sample_strobe,
  input  logic                  underrun,
  input  logic [window_log2:0]  level,
  input  logic                  level_valid,
  output int                    value_errors,
  output int                    protocol_errors
);

  localparam int period = 1 << window_log2;
  // 1/64 of a full window
  localparam int tol = period / 64;

  int since_strobe;
  int since_pulse;
  int exp_level;
  int diff;

  initial begin
    value_errors = 0;
    protocol_errors = 0;
    since_strobe = 0;
    since_pulse = 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      // reset restarts both the strobe age and the meter window
      since_strobe = 0;
      since_pulse = 0;
    end else begin
      // density over a finished window
      if (level_valid && check_en) begin
        exp_level = (exp_density * period) / 1024;
        diff = int'(level) - exp_level;
        if (diff < -tol || diff > tol) begin
          $display("Fail level: got %h expected %h (+/- %h), order %s",
                   level, exp_level, tol, order.name());
          value_errors++;
        end
      end

      // underrun may rise one cycle early or late
      if (underrun && since_strobe < hold_limit - 1) begin
        $display("Fail underrun: got %h expected %h, %0d cycles after last strobe",
                 underrun, 1'b0, since_strobe);
        value_errors++;
      end else if (!underrun && since_strobe > hold_limit) begin
        $display("Fail underrun: got %h expected %h, %0d cycles after last strobe",
                 underrun, 1'b1, since_strobe);
        value_errors++;
      end
      if (sample_strobe) begin
        since_strobe = 0;
      end else begin
        since_strobe++;
      end

      // meter pulse spacing
      if (level_valid) begin
        if (since_pulse != period) begin
          $display("level_valid pulse came %0d cycles into the window instead of %0d",
                   since_pulse, period);
          protocol_errors++;
        end
        since_pulse = 1;
      end else begin
        if (since_pulse == period) begin
          $display("level_valid pulse missing at the end of a window");
          protocol_errors++;
        end
        since_pulse++;
      end
    end
  end

endmodule

// File: audio_dac_chk.sv
`timescale 1ns/1ps

module audio_dac_chk (
  input  logic                     clk,
  input  logic                     rst,
  input  audio_pkg::dsm_order_e    order,
  input  logic                     sample_strobe,
  input  logic                     pdm_out,
  input  logic                     underrun,
  input  logic                     level_valid,
  input  audio_pkg::intake_state_e intake_state
);

  int assert_errors = 0;

  // second order never drives two ones back to back
  no_double_one: assert property (@(posedge clk) disable iff (rst)
    (order == audio_pkg::order_second && pdm_out) |=> !pdm_out)
  else begin
    $error("pdm_out high in two consecutive cycles under second order");
    assert_errors++;
  end

  // outputs come out of reset low
  quiet_after_reset: assert property (@(posedge clk)
    rst |=> (!pdm_out && !underrun && !level_valid))
  else begin
    $error("pdm_out, underrun or level_valid high right after reset");
    assert_errors++;
  end

  single_cycle_valid: assert property (@(posedge clk) disable iff (rst)
    level_valid |=> !level_valid)
  else begin
    $error("level_valid high for two cycles in a row");
    assert_errors++;
  end

  // a strobe brings the intake back to live with the flag low
  strobe_clears_underrun: assert property (@(posedge clk) disable iff (rst)
    sample_strobe |=> (intake_state == audio_pkg::st_live && !underrun))
  else begin
    $error("intake state or underrun not back to live after a strobe");
    assert_errors++;
  end

  // silence persists until the next strobe
  underrun_until_strobe: assert property (@(posedge clk) disable iff (rst)
    (intake_state == audio_pkg::st_underrun && !sample_strobe) |=>
      (intake_state == audio_pkg::st_underrun && underrun))
  else begin
    $error("intake state or underrun left underrun without a strobe");
    assert_errors++;
  end

endmodule

bind audio_dac_top audio_dac_chk u_chk (
  .clk          (clk),
  .rst          (rst),
  .order        (order),
  .sample_strobe(sample_strobe),
  .pdm_out      (pdm_out),
  .underrun     (underrun),
  .level_valid  (level_valid),
  .intake_state (u_intake.state)
);

// File: audio_dac_top.sv
`timescale 1ns/1ps

module audio_dac_top #(
  parameter int hold_limit = 4096,
  parameter int window_log2 = 12
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic signed [audio_pkg::sample_w-1:0] sample,
  input  logic                                 sample_strobe,
  input  audio_pkg::dsm_order_e                order,
  output logic                                 pdm_out,
  output logic                                 underrun,
  output logic [window_log2:0]                 level,
  output logic                                 level_valid
);

  logic [audio_pkg::sample_w-1:0] held_sample;
  logic mod_bit;

  // holds the last strobed sample, silence once the source stalls
  sample_intake #(
    .hold_limit(hold_limit)
  ) u_intake (
    .clk          (clk),
    .rst          (rst),
    .sample       (sample),
    .sample_strobe(sample_strobe),
    .held_sample  (held_sample),
    .underrun     (underrun)
  );

  dsm_modulator u_mod (
    .clk        (clk),
    .rst        (rst),
    .held_sample(held_sample),
    .order      (order),
    .mod_bit    (mod_bit)
  );

  // pin register and windowed ones meter
  pdm_output_stage #(
    .window_log2(window_log2)
  ) u_out (
    .clk        (clk),
    .rst        (rst),
    .mod_bit    (mod_bit),
    .pdm_out    (pdm_out),
    .level      (level),
    .level_valid(level_valid)
  );

endmodule

// File: pdm_output_stage.sv
`timescale 1ns/1ps

module pdm_output_stage #(
  parameter int window_log2 = 12
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 mod_bit,
  output logic                 pdm_out,
  output logic [window_log2:0] level,
  output logic                 level_valid
);

  logic [window_log2-1:0] win_cnt;
  logic [window_log2:0] ones;
  logic [window_log2:0] ones_next;
  logic window_end;

  // pin register, keeps the modulator logic off the pad
  always_ff @(posedge clk) begin
    if (rst) begin
      pdm_out <= 1'b0;
    end else begin
      pdm_out <= mod_bit;
    end
  end

  // last cycle of a window when the free-running counter is all ones
  assign window_end = &win_cnt;

  // includes the bit on the pin this cycle
  assign ones_next = ones + (window_log2 + 1)'(pdm_out);

  always_ff @(posedge clk) begin
    if (rst) begin
      win_cnt <= '0;
      ones <= '0;
      level <= '0;
      level_valid <= 1'b0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
      level_valid <= window_end;
      if (window_end) begin
        level <= ones_next;
        ones <= '0;
      end else begin
        ones <= ones_next;
      end
    end
  end

endmodule

// File: dsm_modulator.sv
`timescale 1ns/1ps

module dsm_modulator (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [audio_pkg::sample_w-1:0] held_sample,
  input  audio_pkg::dsm_order_e         order,
  output logic                          mod_bit
);

  localparam int sw = audio_pkg::sample_w;

  // galois lfsr with taps at bits 23, 22, 17 and 0
  localparam logic [23:0] lfsr_taps = 24'hC20001;
  localparam logic [23:0] lfsr_seed = 24'hFFFFFF;

  // first order scaling where one full-scale pulse is 0x20000
  localparam logic [19:0] full_scale1 = 20'h20000;
  localparam logic [19:0] bias1 = 20'h02000;

  // second order scaling where 0x80000 is one and the integrators clip at +/-8
  localparam logic [23:0] full_scale2 = 24'h080000;
  localparam logic [23:0] pos_limit = 24'h400000;
  localparam logic [23:0] neg_limit = 24'hC00000;

  logic [sw-1:0] ob_sample;

  logic [23:0] lfsr;
  logic [19:0] err_acc;
  logic [19:0] err_step;
  logic [19:0] dither_thresh;
  logic bit1;

  logic [sw+1:0] sample_ext;
  logic [sw+1:0] scaled_sample;
  logic [sw+1:0] ob_scaled;
  logic [23:0] fb2;
  logic [23:0] a_int;
  logic [23:0] b_int;
  logic [23:0] a_step;
  logic [23:0] b_step;
  logic [23:0] a_sum;
  logic [23:0] b_sum;
  logic [23:0] a_next;
  logic [23:0] b_next;
  logic last_bit;
  logic bit2;

  // clip an integrator that left the +/-8 range
  function automatic logic [23:0] saturate(input logic [23:0] v);
    logic [23:0] r;
    r = v;
    if (v[23] && !v[22]) begin
      r = neg_limit;
    end else if (!v[23] && v[22]) begin
      r = pos_limit;
    end
    return r;
  endfunction

  // offset binary where 0 is most negative and 0x8000 is silence
  assign ob_sample = {~held_sample[sw-1], held_sample[sw-2:0]};

  // first order loop

  // the threshold wanders by up to half of full scale
  assign dither_thresh = full_scale1 + 20'(lfsr[23:8]);

  // the accumulator stays between 0x2000 and 0x42000 once running
  assign bit1 = (err_acc >= dither_thresh);

  assign err_step = 20'(ob_sample) + bias1 - (bit1 ? full_scale1 : 20'h0);

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= lfsr_seed;
      err_acc <= '0;
    end else begin
      lfsr <= {lfsr[22:0], 1'b0} ^ (lfsr[23] ? lfsr_taps : 24'h0);
      err_acc <= err_acc + err_step;
    end
  end

  // second order loop

  // three quarters of full scale keeps the integrators out of clipping
  assign sample_ext = {{2{held_sample[sw-1]}}, held_sample};
  assign scaled_sample = sample_ext + {sample_ext[sw:0], 1'b0};
  assign ob_scaled = {~scaled_sample[sw+1], scaled_sample[sw:0]};

  // at most one clock high in a row, so pin rise and fall mismatch
  // adds the same error to every pulse
  assign bit2 = !last_bit && !b_int[23];

  assign fb2 = bit2 ? full_scale2 : 24'h0;

  always_comb begin
    a_step = 24'(ob_scaled) - fb2;
    a_sum = a_int + a_step;
    // second stage sees the unclipped first stage sum
    b_step = a_sum - fb2;
    b_sum = b_int + b_step;
    a_next = saturate(a_sum);
    b_next = saturate(b_sum);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      a_int <= '0;
      b_int <= '0;
      last_bit <= 1'b0;
    end else begin
      a_int <= a_next;
      b_int <= b_next;
      last_bit <= bit2;
    end
  end

  // both loops run and order picks the one that reaches the pin
  assign mod_bit = (order == audio_pkg::order_second) ? bit2 : bit1;

endmodule

// File: sample_intake.sv
`timescale 1ns/1ps

module sample_intake #(
  parameter int hold_limit = 4096
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [audio_pkg::sample_w-1:0] sample,
  input  logic                          sample_strobe,
  output logic [audio_pkg::sample_w-1:0] held_sample,
  output logic                          underrun
);

  // counter must reach hold_limit without wrapping
  localparam int age_w = $clog2(hold_limit + 1);

  audio_pkg::intake_state_e state;
  logic [age_w-1:0] age;
  logic [audio_pkg::sample_w-1:0] sample_q;
  logic age_expired;

  // last live cycle before the source is declared stalled
  assign age_expired = (age == age_w'(hold_limit - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= audio_pkg::st_live;
      age <= '0;
      sample_q <= '0;
    end else if (sample_strobe) begin
      // a fresh sample always brings the path back to live
      state <= audio_pkg::st_live;
      age <= '0;
      sample_q <= sample;
    end else if (state == audio_pkg::st_live) begin
      age <= age + 1'b1;
      if (age_expired) begin
        state <= audio_pkg::st_underrun;
      end
    end
  end

  // zero is mid-scale in two's complement, so the output goes quiet
  assign held_sample = (state == audio_pkg::st_underrun) ? '0 : sample_q;
  assign underrun = (state == audio_pkg::st_underrun);

endmodule

// File: audio_pkg.sv
package audio_pkg;

  // pcm sample width used across the audio path
  localparam int sample_w = 16;

  // delta-sigma loop selection
  // first order uses lfsr dither, second order saturates and
  // forbids back-to-back ones at the pin
  typedef enum logic {
    order_first  = 1'b0,
    order_second = 1'b1
  } dsm_order_e;

  // intake state
  // st_live passes the latched sample through
  // st_underrun substitutes mid-scale silence until the next strobe
  typedef enum logic {
    st_live     = 1'b0,
    st_underrun = 1'b1
  } intake_state_e;

endpackage
